/* exec_stage.sv */
`timescale 1ns/1ps
`include "rvp_params.svh"

module exec_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                op_valid,
    input  rvp_pkg::issue_t     op_instr,
    input  rvp_pkg::operands_t  operands,
    output rvp_pkg::ex_fwd_t    ex_fwd,
    output logic                retire_valid,
    output rvp_pkg::retire_t    retire
);

    logic [`RVP_XLEN-1:0] alu_result;
    logic [5:0]           shamt;

    assign shamt = operands.b[5:0];

    // ====================
    // ALU
    // ====================

    always_comb begin
        case (op_instr.op)
            rvp_pkg::alu_add:    alu_result = operands.a + operands.b;
            rvp_pkg::alu_sub:    alu_result = operands.a - operands.b;
            rvp_pkg::alu_and:    alu_result = operands.a & operands.b;
            rvp_pkg::alu_or:     alu_result = operands.a | operands.b;
            rvp_pkg::alu_xor:    alu_result = operands.a ^ operands.b;
            rvp_pkg::alu_sll:    alu_result = operands.a << shamt;
            rvp_pkg::alu_srl:    alu_result = operands.a >> shamt; // logical, zero fill
            rvp_pkg::alu_pass_b: alu_result = operands.b;
            default:             alu_result = operands.b;
        endcase
    end

    // ====================
    // forward bus
    // ====================

    // this is the only place that decides whether a register gets written
    always_comb begin
        ex_fwd.valid  = op_valid && (op_instr.rd != '0);
        ex_fwd.rd     = op_instr.rd;
        ex_fwd.result = alu_result;
    end

    // ====================
    // retire
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= op_valid; // rd 0 retires too
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            retire.rd     <= op_instr.rd;
            retire.result <= alu_result;
        end
    end

endmodule

/* operand_bypass.sv */
`timescale 1ns/1ps
`include "rvp_params.svh"

module operand_bypass (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   bypass_en,
    input  logic                   issue_valid,
    input  rvp_pkg::issue_t        issue,
    input  logic [`RVP_XLEN-1:0]   rs1_data,
    input  logic [`RVP_XLEN-1:0]   rs2_data,
    input  rvp_pkg::ex_fwd_t       ex_fwd,
    output logic                   op_valid,
    output rvp_pkg::issue_t        op_instr,
    output rvp_pkg::operands_t     operands,
    output logic [1:0]             fwd_hits
);

    logic               hit_a;
    logic               hit_b;
    rvp_pkg::operands_t opnd_next;

    // ====================
    // source selection
    // ====================

    always_comb begin
        hit_a = bypass_en && ex_fwd.valid && (issue.rs1 == ex_fwd.rd);
        // an immediate b never counts as a forward
        hit_b = bypass_en && ex_fwd.valid && !issue.use_imm && (issue.rs2 == ex_fwd.rd);

        opnd_next.a = hit_a ? ex_fwd.result : rs1_data;

        if (issue.use_imm) begin
            opnd_next.b = issue.imm;
        end else if (hit_b) begin
            opnd_next.b = ex_fwd.result;
        end else begin
            opnd_next.b = rs2_data; // with bypass off this is stale on a hazard
        end
    end

    // ====================
    // capture registers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
            fwd_hits <= 2'b00;
        end else begin
            op_valid <= issue_valid;
            fwd_hits <= {hit_b, hit_a} & {2{issue_valid}}; // one pulse per forwarded operand
        end
    end

    // payload only matters while op_valid is high
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            op_instr <= issue;
            operands <= opnd_next;
        end
    end

endmodule

/* operand_pipe_asserts.sv */
`timescale 1ns/1ps
`include "rvp_params.svh"

module operand_pipe_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  issue_valid,
    input logic                  retire_valid,
    input logic [1:0]            fwd_hits,
    input logic                  bypass_en,
    input rvp_pkg::issue_t       issue,
    input logic [`RVP_XLEN-1:0]  rs1_data,
    input logic [`RVP_XLEN-1:0]  rs2_data
);

    int unsigned fail_cnt = 0;

    // ====================
    // timing
    // ====================

    // sampled at one edge, captured by the bypass, retired at the next edge
    a_retire_two_edges: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid == $past(issue_valid, 2))
        else begin
            fail_cnt++;
            $error("retire_valid does not follow issue_valid by exactly two edges");
        end

    // hits registered at an edge were formed with bypass_en as it stood before it
    a_no_hits_when_off: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(bypass_en) |-> (fwd_hits == 2'b00))
        else begin
            fail_cnt++;
            $error("fwd_hits pulsed while bypass was disabled");
        end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((issue.rs1 != '0) || (rs1_data == '0)) && ((issue.rs2 != '0) || (rs2_data == '0)))
        else begin
            fail_cnt++;
            $error("register file returned nonzero data for x0");
        end

endmodule

bind operand_pipe_top operand_pipe_asserts asserts_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .retire_valid (retire_valid),
    .fwd_hits     (fwd_hits),
    .bypass_en    (bypass_en),
    .issue        (issue),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
);

/* operand_pipe_tb.sv */
`timescale 1ns/1ps
`include "rvp_params.svh"

module operand_pipe_tb;

    localparam logic [31:0] SEED          = 32'h10131eff;
    localparam int          RUN_CYCLES    = 400;
    localparam int          DRAIN_TIMEOUT = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   issue_valid;
    rvp_pkg::issue_t        issue;
    logic                   cfg_we;
    logic                   cfg_addr;
    logic [`RVP_CFG_W-1:0]  cfg_wdata;
    logic [`RVP_CFG_W-1:0]  cfg_rdata;
    logic                   retire_valid;
    rvp_pkg::retire_t       retire;

    // reference model state
    logic [`RVP_XLEN-1:0]   model_rf [`RVP_NUM_REGS];
    logic                   pend_valid;    // write from the instruction now in execute
    logic [`RVP_REG_ADDR_W-1:0] pend_rd;
    logic [`RVP_XLEN-1:0]   pend_result;
    logic                   model_bypass;
    logic [`RVP_CFG_W-1:0]  fwd_count;
    rvp_pkg::retire_t       exp_q [$];
    int                     due_q [$];     // cycle at which each retire must show up
    int                     cycle;

    operand_pipe_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #50 clk = ~clk;

    // ====================
    // reporting
    // ====================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at cycle %0d", cycle);
    endtask

    task automatic check_retire(input rvp_pkg::retire_t exp, input rvp_pkg::retire_t act);
        if (exp !== act) begin
            $display("MISMATCH retire expected rd=%h result=%h actual rd=%h result=%h",
                     exp.rd, exp.result, act.rd, act.result);
            abort_run("retired result differs from the model");
        end
    endtask

    task automatic check_cfg(input string name, input logic [`RVP_CFG_W-1:0] exp,
                             input logic [`RVP_CFG_W-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run("configuration readback differs from the model");
        end
    endtask

    // ====================
    // model
    // ====================

    function automatic logic [`RVP_XLEN-1:0] alu_model(input rvp_pkg::alu_op_e op,
                                                       input logic [`RVP_XLEN-1:0] a,
                                                       input logic [`RVP_XLEN-1:0] b);
        case (op)
            rvp_pkg::alu_add: return a + b;
            rvp_pkg::alu_sub: return a - b;
            rvp_pkg::alu_and: return a & b;
            rvp_pkg::alu_or:  return a | b;
            rvp_pkg::alu_xor: return a ^ b;
            rvp_pkg::alu_sll: return a << b[5:0];
            rvp_pkg::alu_srl: return a >> b[5:0];
            default:          return b;
        endcase
    endfunction

    // called once per cycle, with what is sampled at the coming edge
    task automatic model_issue(input logic v, input rvp_pkg::issue_t ins);
        logic                 hit_a;
        logic                 hit_b;
        logic [`RVP_XLEN-1:0] a;
        logic [`RVP_XLEN-1:0] b;
        logic [`RVP_XLEN-1:0] res;
        rvp_pkg::retire_t     exp;
        hit_a = model_bypass && pend_valid && (ins.rs1 == pend_rd);
        hit_b = model_bypass && pend_valid && !ins.use_imm && (ins.rs2 == pend_rd);
        a = hit_a ? pend_result : model_rf[ins.rs1]; // model_rf still lacks the pending write
        b = ins.use_imm ? ins.imm : (hit_b ? pend_result : model_rf[ins.rs2]);
        res = alu_model(ins.op, a, b);
        if (pend_valid) begin
            model_rf[pend_rd] = pend_result;
        end
        pend_valid  = v && (ins.rd != '0);
        pend_rd     = ins.rd;
        pend_result = res;
        if (v) begin
            fwd_count = fwd_count + {31'b0, hit_a} + {31'b0, hit_b};
            exp.rd     = ins.rd;
            exp.result = res;
            exp_q.push_back(exp);
            due_q.push_back(cycle + 2);
        end
    endtask

    // ====================
    // stimulus
    // ====================

    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("retire_valid pulsed with no instruction outstanding");
            end
            if (due_q[0] != cycle) begin
                abort_run("an instruction retired at the wrong cycle");
            end
            check_retire(exp_q.pop_front(), retire);
            void'(due_q.pop_front());
        end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
            abort_run("an issued instruction did not retire two edges after issue");
        end
    endtask

    task automatic drive_issue(input logic v, input rvp_pkg::issue_t ins);
        issue_valid = v;
        issue       = ins;
        model_issue(v, ins);
    endtask

    // mostly x0..x3 so that hazards come up often
    function automatic logic [`RVP_REG_ADDR_W-1:0] pick_reg();
        logic [31:0] r;
        r = ($urandom_range(7, 0) == 0) ? $urandom_range(`RVP_NUM_REGS - 1, 0)
                                         : $urandom_range(3, 0);
        return r[`RVP_REG_ADDR_W-1:0];
    endfunction

    task automatic run_random(input int n);
        rvp_pkg::issue_t ins;
        logic [31:0]     r;
        for (int i = 0; i < n; i++) begin
            next_cycle();
            r           = $urandom_range(7, 0);
            ins.op      = rvp_pkg::alu_op_e'(r[2:0]);
            ins.use_imm = ($urandom_range(3, 0) == 0);
            ins.rd      = pick_reg();
            ins.rs1     = pick_reg();
            ins.rs2     = pick_reg();
            ins.imm     = {$urandom, $urandom};
            drive_issue($urandom_range(9, 0) < 8, ins); // about 80% busy
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
            drive_issue(1'b0, '0);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("timed out waiting for retire_valid on outstanding instructions");
            end
        end
        next_cycle(); // lets the last fwd_hits reach the counter
        drive_issue(1'b0, '0);
    endtask

    task automatic cfg_write(input logic addr, input logic [`RVP_CFG_W-1:0] data);
        next_cycle();
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        drive_issue(1'b0, '0);
        if (addr) begin
            fwd_count = '0;
        end else begin
            model_bypass = data[0];
        end
        next_cycle();
        cfg_we = 1'b0;
        drive_issue(1'b0, '0);
    endtask

    task automatic cfg_check(input logic addr, input logic [`RVP_CFG_W-1:0] exp);
        next_cycle();
        cfg_addr = addr;
        drive_issue(1'b0, '0);
        next_cycle(); // read mux settled a full half period ago
        check_cfg(addr ? "cfg_rdata(fwd_cnt)" : "cfg_rdata(ctrl)", exp, cfg_rdata);
        drive_issue(1'b0, '0);
    endtask

    // ====================
    // test sequence
    // ====================

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        cfg_we       = 1'b0;
        cfg_addr     = 1'b0;
        cfg_wdata    = '0;
        pend_valid   = 1'b0;
        pend_rd      = '0;
        pend_result  = '0;
        model_bypass = 1'b1;
        fwd_count    = '0;
        cycle        = 0;
        for (int i = 0; i < `RVP_NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        void'($urandom(SEED));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        cfg_check(1'b0, 32'h1);
        cfg_check(1'b1, '0);

        run_random(RUN_CYCLES); // bypass on
        drain();
        cfg_check(1'b1, fwd_count);
        cfg_write(1'b1, 32'hffff_ffff);
        cfg_check(1'b1, '0);

        cfg_write(1'b0, '0);
        cfg_check(1'b0, '0);
        run_random(RUN_CYCLES); // stale operands on every back-to-back hazard
        drain();
        cfg_check(1'b1, fwd_count);

        cfg_write(1'b0, 32'h1);
        cfg_check(1'b0, 32'h1);
        run_random(RUN_CYCLES / 2);
        drain();
        cfg_check(1'b1, fwd_count);

        if (dut_i.asserts_i.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("concurrent assertions failed during the run");
        end
    end

endmodule

/* operand_pipe_top.sv */
`timescale 1ns/1ps
`include "rvp_params.svh"

module operand_pipe_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  rvp_pkg::issue_t        issue,
    input  logic                   cfg_we,
    input  logic                   cfg_addr,
    input  logic [`RVP_CFG_W-1:0]  cfg_wdata,
    output logic [`RVP_CFG_W-1:0]  cfg_rdata,
    output logic                   retire_valid,
    output rvp_pkg::retire_t       retire
);

    logic [`RVP_XLEN-1:0] rs1_data;
    logic [`RVP_XLEN-1:0] rs2_data;
    rvp_pkg::ex_fwd_t     ex_fwd;    // bypass source and register file write port
    logic                 op_valid;
    rvp_pkg::issue_t      op_instr;
    rvp_pkg::operands_t   operands;
    logic [1:0]           fwd_hits;
    logic                 bypass_en;

    // ====================
    // operand read
    // ====================

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (issue.rs1),
        .rs2      (issue.rs2),
        .wr       (ex_fwd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    operand_bypass operand_bypass_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bypass_en   (bypass_en),
        .issue_valid (issue_valid),
        .issue       (issue),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_fwd      (ex_fwd),
        .op_valid    (op_valid),
        .op_instr    (op_instr),
        .operands    (operands),
        .fwd_hits    (fwd_hits)
    );

    pipe_cfg pipe_cfg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .fwd_hits  (fwd_hits),
        .bypass_en (bypass_en)
    );

    // ====================
    // execute
    // ====================

    exec_stage exec_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op_instr     (op_instr),
        .operands     (operands),
        .ex_fwd       (ex_fwd),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* pipe_cfg.sv */
`timescale 1ns/1ps
`include "rvp_params.svh"

module pipe_cfg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_we,
    input  logic                   cfg_addr,
    input  logic [`RVP_CFG_W-1:0]  cfg_wdata,
    output logic [`RVP_CFG_W-1:0]  cfg_rdata,
    input  logic [1:0]             fwd_hits,
    output logic                   bypass_en
);

    logic [`RVP_CFG_W-1:0] fwd_cnt;
    logic [1:0]            hit_sum;

    assign hit_sum = {1'b0, fwd_hits[0]} + {1'b0, fwd_hits[1]};

    // ====================
    // registers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bypass_en <= 1'b1; // forwarding is on out of reset
        end else if (cfg_we && !cfg_addr) begin
            bypass_en <= cfg_wdata[0];
        end
    end

    // any write to address 1 clears, and wins over this cycle's hits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_cnt <= '0;
        end else if (cfg_we && cfg_addr) begin
            fwd_cnt <= '0;
        end else begin
            fwd_cnt <= fwd_cnt + {{(`RVP_CFG_W-2){1'b0}}, hit_sum}; // wraps, no saturation
        end
    end

    // read mux
    assign cfg_rdata = cfg_addr ? fwd_cnt : {{(`RVP_CFG_W-1){1'b0}}, bypass_en};

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "rvp_params.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`RVP_REG_ADDR_W-1:0]  rs1,
    input  logic [`RVP_REG_ADDR_W-1:0]  rs2,
    input  rvp_pkg::ex_fwd_t            wr,
    output logic [`RVP_XLEN-1:0]        rs1_data,
    output logic [`RVP_XLEN-1:0]        rs2_data
);

    logic [`RVP_XLEN-1:0] regs [`RVP_NUM_REGS];

    // ====================
    // write port
    // ====================

    // x0 stays zero because execute never raises valid for rd 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RVP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid) begin
            regs[wr.rd] <= wr.result;
        end
    end

    // ====================
    // read ports
    // ====================

    // a write in the same cycle is not visible here, the bypass covers that case
    always_comb begin
        rs1_data = regs[rs1];
        rs2_data = regs[rs2];
    end

endmodule

/* rvp_params.svh */
`ifndef RVP_PARAMS_SVH
`define RVP_PARAMS_SVH

// ====================
// datapath sizes
// ====================

// integer register and ALU width
`define RVP_XLEN 64

`define RVP_REG_ADDR_W 5 // enough to name every architectural register
`define RVP_NUM_REGS 32

// ====================
// configuration port
// ====================

`define RVP_CFG_W 32 // width of cfg_wdata, cfg_rdata and the forward counter

`endif

/* rvp_pkg.sv */
`include "rvp_params.svh"

package rvp_pkg;

    // ====================
    // ALU operations
    // ====================

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_sll    = 3'd5, // shift amount comes from the low 6 bits of b
        alu_srl    = 3'd6,
        alu_pass_b = 3'd7  // result is operand b unchanged
    } alu_op_e;

    // ====================
    // pipeline payloads
    // ====================

    typedef struct packed {
        alu_op_e                     op;
        logic                        use_imm; // b comes from imm instead of rs2
        logic [`RVP_REG_ADDR_W-1:0]  rd;
        logic [`RVP_REG_ADDR_W-1:0]  rs1;
        logic [`RVP_REG_ADDR_W-1:0]  rs2;
        logic [`RVP_XLEN-1:0]        imm;
    } issue_t;

    typedef struct packed {
        logic [`RVP_XLEN-1:0] a;
        logic [`RVP_XLEN-1:0] b;
    } operands_t;

    // valid is only set when the execute instruction really writes a register
    typedef struct packed {
        logic                        valid;
        logic [`RVP_REG_ADDR_W-1:0]  rd;
        logic [`RVP_XLEN-1:0]        result;
    } ex_fwd_t;

    typedef struct packed {
        logic [`RVP_REG_ADDR_W-1:0]  rd;
        logic [`RVP_XLEN-1:0]        result;
    } retire_t;

endpackage

/* vlog.f */
+incdir+.
rvp_pkg.sv
reg_file.sv
operand_bypass.sv
pipe_cfg.sv
exec_stage.sv
operand_pipe_top.sv
operand_pipe_asserts.sv
operand_pipe_tb.sv
